/* hw/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// word index width of the shared banks, 2048 words
// index is segment bit 0 followed by offset bits 11:2
`define MEM_WORD_BITS 11

// upper halfword of a data address per memory segment
`define SEG_KERNEL 16'h0000
`define SEG_PROG 16'h0001

// upper 20 bits of the device page
`define MMIO_PAGE 20'hAAAAA

// device offsets inside the page
`define MMIO_DISP_OFS 12'h008
`define MMIO_UART_TX_OFS 12'h400
// status and receive window starts here
`define MMIO_UART_ST_OFS 12'h404
// first offset past the uart window
`define MMIO_UART_END 12'h408

// transmit credits held after reset
`define UART_TX_CREDITS 4

`endif

/* hw/mem_bus_pkg.sv */
package mem_bus_pkg;

    // device view of an address
    // page picks the mmio page, ofs the register in it
    typedef struct packed {
        logic [19:0] page;
        logic [11:0] ofs;
    } mmio_addr_t;

    // memory view of an address
    // seg picks kernel or program space
    typedef struct packed {
        logic [15:0] seg;
        logic [15:0] ofs;
    } seg_addr_t;

    // one address word, decoded both ways
    typedef union packed {
        mmio_addr_t mmio;
        seg_addr_t  mem;
    } mem_addr_u;

    // data side request from the core, one per cycle
    typedef struct packed {
        mem_addr_u   addr;
        logic [31:0] wdata;
        // lane mask, also shapes the load result
        logic [3:0]  byte_en;
        logic        we;
        logic        re;
    } mem_req_t;

    // instruction fetch request
    typedef struct packed {
        logic        en;
        logic [31:0] addr;
    } fetch_req_t;

endpackage

/* hw/mmio_pkg.sv */
package mmio_pkg;

    // one byte toward the external uart
    // valid is a single cycle pulse
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } uart_tx_t;

    // display data register write
    // wea pulses one cycle after the store
    typedef struct packed {
        logic        wea;
        logic [31:0] dat;
    } disp_wr_t;

endpackage

/* hw/store_aligner.sv */
`include "mem_defs.svh"

module store_aligner (
    input  logic                       clk,
    input  logic                       rst,
    input  mem_bus_pkg::mem_req_t      req,
    output logic [`MEM_WORD_BITS-1:0]  word_idx,
    output logic [3:0]                 lane_we,
    output logic [3:0][7:0]            lane_wdata
);

    logic        mem_region;
    logic        wr_armed;
    logic [31:0] shifted;

    // only kernel and program segments are writable
    // anything else is dropped, mmio included
    assign mem_region = (req.addr.mem.seg == `SEG_KERNEL) ||
                        (req.addr.mem.seg == `SEG_PROG);

    // same index for all four lanes
    // unmapped segments alias by their low bit
    assign word_idx = {req.addr.mem.seg[0], req.addr.mem.ofs[11:2]};

    // bank writes open from the first cycle after reset release
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_armed <= 1'b0;
        end else begin
            wr_armed <= 1'b1;
        end
    end

    assign lane_we = (wr_armed && req.we && mem_region) ? req.byte_en : 4'b0000;

    // move the low byte or halfword up to the enabled lanes
    always_comb begin
        case (req.byte_en)
            4'b0001: shifted = {24'h0, req.wdata[7:0]};
            4'b0010: shifted = {16'h0, req.wdata[7:0], 8'h0};
            4'b0100: shifted = {8'h0, req.wdata[7:0], 16'h0};
            4'b1000: shifted = {req.wdata[7:0], 24'h0};
            4'b0011: shifted = {16'h0, req.wdata[15:0]};
            4'b0110: shifted = {8'h0, req.wdata[15:0], 8'h0};
            4'b1100: shifted = {req.wdata[15:0], 16'h0};
            // full word and odd masks go through as is
            default: shifted = req.wdata;
        endcase
    end

    // lane i carries bits 8i+7:8i
    assign lane_wdata = shifted;

endmodule

/* hw/mem_lane_bank.sv */
`include "mem_defs.svh"

module mem_lane_bank (
    input  logic                       clk,
    input  logic [`MEM_WORD_BITS-1:0]  idx,
    input  logic                       we,
    input  logic [7:0]                 wdata,
    output logic [7:0]                 rdata,
    input  logic [`MEM_WORD_BITS-1:0]  fetch_idx,
    input  logic                       fetch_en,
    output logic [7:0]                 fetch_rdata
);

    // one byte lane of the shared memory
    logic [7:0] ram [2**`MEM_WORD_BITS];

    // data port, read every cycle
    // write first, so a store shows its own byte next cycle
    always_ff @(posedge clk) begin
        if (we) begin
            ram[idx] <= wdata;
            rdata    <= wdata;
        end else begin
            rdata <= ram[idx];
        end
    end

    // fetch port, read only
    // holds its last byte while fetch is idle
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            fetch_rdata <= ram[fetch_idx];
        end
    end

endmodule

/* hw/load_aligner.sv */
module load_aligner (
    input  logic            clk,
    input  logic            rst,
    input  logic [3:0]      byte_en,
    input  logic [3:0][7:0] lane_rdata,
    output logic [31:0]     rdata
);

    logic [3:0]  byte_en_q;
    logic [31:0] word;

    // banks answer one cycle late
    // so the mask has to line up with them
    always_ff @(posedge clk) begin
        if (rst) begin
            byte_en_q <= 4'b0000;
        end else begin
            byte_en_q <= byte_en;
        end
    end

    // lane 0 at the bottom
    assign word = lane_rdata;

    // pull the chosen lane or pair down, zero extended
    always_comb begin
        case (byte_en_q)
            4'b0001: rdata = {24'h0, word[7:0]};
            4'b0010: rdata = {24'h0, word[15:8]};
            4'b0100: rdata = {24'h0, word[23:16]};
            4'b1000: rdata = {24'h0, word[31:24]};
            4'b0011: rdata = {16'h0, word[15:0]};
            4'b0110: rdata = {16'h0, word[23:8]};
            4'b1100: rdata = {16'h0, word[31:16]};
            // full word, also right after reset
            default: rdata = word;
        endcase
    end

endmodule

/* hw/mmio_ctrl.sv */
`include "mem_defs.svh"

module mmio_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_bus_pkg::mem_req_t  req,
    input  logic                   tx_credit,
    input  logic                   rx_valid,
    input  logic [7:0]             rx_data,
    output mmio_pkg::uart_tx_t     uart_tx,
    output mmio_pkg::disp_wr_t     disp_wr,
    output logic [31:0]            mmio_rdata,
    output logic                   mmio_sel
);

    // room for 0 up to the full credit count
    localparam int cred_w = $clog2(`UART_TX_CREDITS + 1);
    localparam logic [cred_w-1:0] cred_max = cred_w'(`UART_TX_CREDITS);

    logic              is_mmio;
    logic [11:0]       ofs;
    logic              disp_hit;
    logic              tx_hit;
    logic              tx_send;
    logic              tx_full;
    logic              uart_win;
    logic              mmio_rd;
    logic              rx_rd;
    logic              rx_present;
    logic [7:0]        rx_byte;
    logic [7:0]        win_byte;
    logic [31:0]       rd_word;
    logic [cred_w-1:0] credits;

    // page and register decode
    assign ofs      = req.addr.mmio.ofs;
    assign is_mmio  = (req.addr.mmio.page == `MMIO_PAGE);
    assign disp_hit = is_mmio && req.we && (ofs == `MMIO_DISP_OFS);
    assign tx_hit   = is_mmio && req.we && (ofs == `MMIO_UART_TX_OFS);
    assign uart_win = is_mmio && (ofs >= `MMIO_UART_TX_OFS) && (ofs < `MMIO_UART_END);
    assign mmio_rd  = is_mmio && req.re;
    assign rx_rd    = mmio_rd && (ofs == `MMIO_UART_TX_OFS);

    // no credits left, store to tx is lost
    assign tx_full = (credits == '0);
    assign tx_send = tx_hit && !tx_full;

    // credit count
    // a return and a send in one cycle leave it alone
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= cred_max;
        end else if (tx_send && !tx_credit) begin
            credits <= credits - 1'b1;
        end else if (tx_credit && !tx_send && (credits != cred_max)) begin
            credits <= credits + 1'b1;
        end
    end

    // tx beat one cycle after the store
    always_ff @(posedge clk) begin
        if (tx_send) begin
            uart_tx.data <= req.wdata[7:0];
        end
        if (rst) begin
            uart_tx.valid <= 1'b0;
        end else begin
            uart_tx.valid <= tx_send;
        end
    end

    // display write, same one cycle delay
    always_ff @(posedge clk) begin
        if (disp_hit) begin
            disp_wr.dat <= req.wdata;
        end
        if (rst) begin
            disp_wr.wea <= 1'b0;
        end else begin
            disp_wr.wea <= disp_hit;
        end
    end

    // receive holding register
    // a new byte wins over a clearing read
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            rx_byte <= rx_data;
        end
        if (rst) begin
            rx_present <= 1'b0;
        end else if (rx_valid) begin
            rx_present <= 1'b1;
        end else if (rx_rd) begin
            rx_present <= 1'b0;
        end
    end

    // 0x400..0x403 give the rx byte, 0x404..0x407 the status
    assign win_byte = (ofs >= `MMIO_UART_ST_OFS) ? {6'b0, tx_full, rx_present} : rx_byte;

    // byte lands in the lane named by address bits 1:0
    // everything outside the uart window reads 0
    always_comb begin
        rd_word = 32'h0;
        if (uart_win) begin
            rd_word = {24'h0, win_byte} << {ofs[1:0], 3'b000};
        end
    end

    // read-back captured with the request
    always_ff @(posedge clk) begin
        if (mmio_rd) begin
            mmio_rdata <= rd_word;
        end
        if (rst) begin
            mmio_sel <= 1'b0;
        end else begin
            mmio_sel <= mmio_rd;
        end
    end

endmodule

/* hw/memory_controller.sv */
`include "mem_defs.svh"

module memory_controller (
    input  logic                     clk,
    input  logic                     rst,
    input  mem_bus_pkg::mem_req_t    mem_req,
    input  mem_bus_pkg::fetch_req_t  fetch_req,
    output logic [31:0]              mem_rdata,
    output logic [31:0]              fetch_rdata,
    output mmio_pkg::uart_tx_t       uart_tx,
    input  logic                     tx_credit,
    input  logic                     rx_valid,
    input  logic [7:0]               rx_data,
    output mmio_pkg::disp_wr_t       disp_wr
);

    import mem_bus_pkg::*;

    logic [`MEM_WORD_BITS-1:0] word_idx;
    logic [`MEM_WORD_BITS-1:0] fetch_idx;
    logic [3:0]                lane_we;
    logic [3:0][7:0]           lane_wdata;
    logic [3:0][7:0]           lane_rdata;
    logic [3:0][7:0]           fetch_lane;
    logic [31:0]               load_word;
    logic [31:0]               mmio_rdata;
    logic                      mmio_sel;
    mem_addr_u                 fetch_addr;

    // region check and lane steering for stores
    store_aligner i_store_aligner (
        .clk        (clk),
        .rst        (rst),
        .req        (mem_req),
        .word_idx   (word_idx),
        .lane_we    (lane_we),
        .lane_wdata (lane_wdata)
    );

    // fetch uses the same segment/offset split as data
    assign fetch_addr = fetch_req.addr;
    assign fetch_idx  = {fetch_addr.mem.seg[0], fetch_addr.mem.ofs[11:2]};

    // one bank per byte lane
    for (genvar i = 0; i < 4; i++) begin : g_lane
        mem_lane_bank i_bank (
            .clk         (clk),
            .idx         (word_idx),
            .we          (lane_we[i]),
            .wdata       (lane_wdata[i]),
            .rdata       (lane_rdata[i]),
            .fetch_idx   (fetch_idx),
            .fetch_en    (fetch_req.en),
            .fetch_rdata (fetch_lane[i])
        );
    end

    // fetch word is the four lanes side by side
    assign fetch_rdata = fetch_lane;

    // load shaping from the mask of the request cycle
    load_aligner i_load_aligner (
        .clk        (clk),
        .rst        (rst),
        .byte_en    (mem_req.byte_en),
        .lane_rdata (lane_rdata),
        .rdata      (load_word)
    );

    // display, uart and mmio read-back
    mmio_ctrl i_mmio_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (mem_req),
        .tx_credit  (tx_credit),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .uart_tx    (uart_tx),
        .disp_wr    (disp_wr),
        .mmio_rdata (mmio_rdata),
        .mmio_sel   (mmio_sel)
    );

    // mmio_sel is registered with the load
    // so both sources line up in cycle n+1
    assign mem_rdata = mmio_sel ? mmio_rdata : load_word;

endmodule

/* verif/tb_memory_controller.sv */
`include "mem_defs.svh"

module tb_memory_controller;

    timeunit 1ns;
    timeprecision 1ps;

    import mem_bus_pkg::*;
    import mmio_pkg::*;

    // one expected response due the cycle after its request
    typedef struct packed {
        logic        valid;
        logic [31:0] exp;
    } chk_t;

    // stimulus needs about 130 cycles
    // limit leaves a wide margin
    localparam int max_cycles = 2000;
    localparam int n_words = 16;

    logic        clk;
    logic        rst;
    mem_req_t    mem_req;
    fetch_req_t  fetch_req;
    logic [31:0] mem_rdata;
    logic [31:0] fetch_rdata;
    uart_tx_t    uart_tx;
    logic        tx_credit;
    logic        rx_valid;
    logic [7:0]  rx_data;
    disp_wr_t    disp_wr;

    // reference memory and device state
    logic [31:0] ref_mem [0:(1 << `MEM_WORD_BITS) - 1];
    int          credits;
    logic        rx_present;
    logic [7:0]  rx_byte;

    int          seed;
    int          cycles;
    int          tx_beats;
    int          disp_pulses;
    logic [31:0] addrs [n_words];

    // set with the request and moved one stage per edge
    chk_t        load_chk;
    chk_t        load_due;
    chk_t        fetch_chk;
    chk_t        fetch_due;
    chk_t        tx_chk;
    chk_t        tx_due;
    chk_t        disp_chk;
    chk_t        disp_due;
    string       load_name;
    string       load_due_name;
    string       fetch_name;
    string       fetch_due_name;

    memory_controller i_dut (
        .clk         (clk),
        .rst         (rst),
        .mem_req     (mem_req),
        .fetch_req   (fetch_req),
        .mem_rdata   (mem_rdata),
        .fetch_rdata (fetch_rdata),
        .uart_tx     (uart_tx),
        .tx_credit   (tx_credit),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .disp_wr     (disp_wr)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // segment bit 0 above word offset bits 11:2
    function automatic logic [`MEM_WORD_BITS-1:0] word_index(input logic [31:0] addr);
        return {addr[16], addr[11:2]};
    endfunction

    // shift byte or halfword up and keep only enabled lanes
    function automatic logic [31:0] merge_store(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0] be);
        logic [31:0] moved;
        logic [31:0] res;
        case (be)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: moved = {4{data[7:0]}};
            4'b0011, 4'b0110: moved = {data[7:0], data[15:0], data[15:8]};
            4'b1100: moved = {data[15:0], 16'h0};
            default: moved = data;
        endcase
        // 0011 takes bits 15:0 straight into lanes 1:0
        if (be == 4'b0011) begin
            moved = {16'h0, data[15:0]};
        end
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = moved[8*i +: 8];
            end
        end
        return res;
    endfunction

    // enabled lanes packed down from lane 0 with zeros above
    function automatic logic [31:0] shape_load(input logic [31:0] word, input logic [3:0] be);
        logic [31:0] res;
        int          n;
        // only single lanes and aligned pairs are narrowed
        case (be)
            4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b0110, 4'b1100: begin
                res = 32'h0;
                n   = 0;
                for (int i = 0; i < 4; i++) begin
                    if (be[i]) begin
                        res[8*n +: 8] = word[8*i +: 8];
                        n = n + 1;
                    end
                end
            end
            default: res = word;
        endcase
        return res;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        $display("TEST FAILED");
        $fatal(1, "stopped at first failed check");
    endtask

    task automatic clear_inputs();
        mem_req   = '0;
        fetch_req = '0;
        tx_credit = 1'b0;
        rx_valid  = 1'b0;
        rx_data   = 8'h00;
        load_chk  = '0;
        fetch_chk = '0;
        tx_chk    = '0;
        disp_chk  = '0;
    endtask

    // inputs change 2 ns after the rising edge
    task automatic advance_cycle();
        @(posedge clk);
        #2;
        clear_inputs();
    endtask

    task automatic store_data(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
        advance_cycle();
        mem_req.addr    = addr;
        mem_req.wdata   = data;
        mem_req.byte_en = be;
        mem_req.we      = 1'b1;
        if (addr[31:16] == `SEG_KERNEL || addr[31:16] == `SEG_PROG) begin
            ref_mem[word_index(addr)] = merge_store(ref_mem[word_index(addr)], data, be);
        end else if (addr[31:12] == `MMIO_PAGE && addr[11:0] == `MMIO_DISP_OFS) begin
            disp_chk = {1'b1, data};
        end else if (addr[31:12] == `MMIO_PAGE && addr[11:0] == `MMIO_UART_TX_OFS) begin
            // at zero credits the beat is dropped
            if (credits > 0) begin
                tx_chk  = {1'b1, 24'h0, data[7:0]};
                credits = credits - 1;
            end
        end
    endtask

    task automatic load_check(input string name, input logic [31:0] addr,
                              input logic [3:0] be);
        logic [11:0] ofs;
        logic [7:0]  win;
        logic [31:0] exp;
        ofs = addr[11:0];
        advance_cycle();
        mem_req.addr    = addr;
        mem_req.byte_en = be;
        mem_req.re      = 1'b1;
        if (addr[31:12] == `MMIO_PAGE) begin
            exp = 32'h0;
            if (ofs >= `MMIO_UART_TX_OFS && ofs < `MMIO_UART_END) begin
                // status byte is {tx_full, rx_present}
                win = (ofs >= `MMIO_UART_ST_OFS) ? {6'b0, credits == 0, rx_present} : rx_byte;
                exp = {24'h0, win} << (8 * ofs[1:0]);
            end
            if (ofs == `MMIO_UART_TX_OFS) begin
                rx_present = 1'b0;
            end
        end else begin
            exp = shape_load(ref_mem[word_index(addr)], be);
        end
        load_chk  = {1'b1, exp};
        load_name = name;
    endtask

    task automatic fetch_check(input string name, input logic [31:0] addr);
        advance_cycle();
        fetch_req.en   = 1'b1;
        fetch_req.addr = addr;
        fetch_chk      = {1'b1, ref_mem[word_index(addr)]};
        fetch_name     = name;
    endtask

    task automatic return_credit();
        advance_cycle();
        tx_credit = 1'b1;
        if (credits < `UART_TX_CREDITS) begin
            credits = credits + 1;
        end
    endtask

    task automatic receive_byte(input logic [7:0] b);
        advance_cycle();
        rx_valid   = 1'b1;
        rx_data    = b;
        rx_present = 1'b1;
        rx_byte    = b;
    endtask

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout, run still going after %0d cycles", max_cycles);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    // move expectations one stage in step with the dut registers
    always @(posedge clk) begin
        load_due       = load_chk;
        load_due_name  = load_name;
        fetch_due      = fetch_chk;
        fetch_due_name = fetch_name;
        tx_due         = tx_chk;
        disp_due       = disp_chk;
    end

    // outputs compared at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (load_due.valid) begin
                assert (mem_rdata === load_due.exp)
                else report_mismatch(load_due_name, load_due.exp, mem_rdata);
            end
            if (fetch_due.valid) begin
                assert (fetch_rdata === fetch_due.exp)
                else report_mismatch(fetch_due_name, fetch_due.exp, fetch_rdata);
            end
            // pulses appear exactly when expected and at no other time
            assert (uart_tx.valid === tx_due.valid)
            else report_mismatch("uart tx pulse", {31'h0, tx_due.valid}, {31'h0, uart_tx.valid});
            assert (disp_wr.wea === disp_due.valid)
            else report_mismatch("display pulse", {31'h0, disp_due.valid}, {31'h0, disp_wr.wea});
            // pulses the dut really drives
            if (uart_tx.valid === 1'b1) begin
                tx_beats = tx_beats + 1;
            end
            if (disp_wr.wea === 1'b1) begin
                disp_pulses = disp_pulses + 1;
            end
            if (tx_due.valid) begin
                assert (uart_tx.data === tx_due.exp[7:0])
                else report_mismatch("uart tx data", tx_due.exp, {24'h0, uart_tx.data});
            end
            if (disp_due.valid) begin
                assert (disp_wr.dat === disp_due.exp)
                else report_mismatch("display data", disp_due.exp, disp_wr.dat);
            end
        end
    end

    initial begin
        seed        = 80;
        cycles      = 0;
        tx_beats    = 0;
        disp_pulses = 0;
        credits     = `UART_TX_CREDITS;
        rx_present  = 1'b0;
        rx_byte     = 8'h00;
        load_name   = "";
        fetch_name  = "";
        clear_inputs();
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // random full words read back right after each store
        for (int i = 0; i < n_words; i++) begin
            addrs[i] = {15'h0, i[0], 4'h0, 10'($random(seed)), 2'b00};
            // keep clear of word 0x100 used by the lane tests
            if (addrs[i][11:2] == 10'h040) begin
                addrs[i][2] = 1'b1;
            end
            store_data(addrs[i], $random(seed), 4'b1111);
            load_check("word store readback", addrs[i], 4'b1111);
        end
        // back to back loads over all of them
        for (int i = 0; i < n_words; i++) begin
            load_check("back to back load", addrs[i], 4'b1111);
        end

        // byte and halfword lanes
        store_data(32'h0000_0100, 32'h1122_3344, 4'b1111);
        for (int i = 0; i < 4; i++) begin
            store_data(32'h0000_0100, $random(seed), 4'b0001 << i);
            load_check("byte lane full word", 32'h0000_0100, 4'b1111);
            load_check("byte lane load", 32'h0000_0100, 4'b0001 << i);
        end
        store_data(32'h0000_0100, $random(seed), 4'b0011);
        load_check("half low full word", 32'h0000_0100, 4'b1111);
        load_check("half low load", 32'h0000_0100, 4'b0011);
        store_data(32'h0000_0100, $random(seed), 4'b0110);
        load_check("half mid full word", 32'h0000_0100, 4'b1111);
        load_check("half mid load", 32'h0000_0100, 4'b0110);
        store_data(32'h0000_0100, $random(seed), 4'b1100);
        load_check("half high full word", 32'h0000_0100, 4'b1111);
        load_check("half high load", 32'h0000_0100, 4'b1100);

        // unmapped segment 2 aliases onto kernel word 0
        store_data(32'h0000_0000, 32'hCAFE_F00D, 4'b1111);
        store_data(32'h0002_0000, 32'h0BAD_0BAD, 4'b1111);
        load_check("unmapped store ignored", 32'h0000_0000, 4'b1111);
        load_check("unmapped load alias", 32'h0002_0000, 4'b1111);

        // fetch port sees data port writes
        for (int i = 0; i < n_words; i++) begin
            fetch_check("fetch readback", addrs[i]);
        end
        fetch_check("fetch lane word", 32'h0000_0100);

        // display register
        store_data(32'hAAAA_A008, $random(seed), 4'b1111);
        store_data(32'hAAAA_A00C, $random(seed), 4'b1111);
        store_data(32'hAAAA_A000, $random(seed), 4'b1111);
        load_check("display load", 32'hAAAA_A008, 4'b1111);

        // uart transmit with four credits then full
        for (int i = 0; i < 5; i++) begin
            store_data(32'hAAAA_A400, $random(seed), 4'b0001);
        end
        load_check("uart status full", 32'hAAAA_A404, 4'b1111);
        return_credit();
        store_data(32'hAAAA_A400, $random(seed), 4'b0001);
        advance_cycle();

        // uart receive with the lane picked by address bits 1:0
        receive_byte(8'($random(seed)));
        load_check("uart status rx", 32'hAAAA_A406, 4'b1111);
        load_check("uart rx lane", 32'hAAAA_A401, 4'b1111);
        load_check("uart rx read", 32'hAAAA_A400, 4'b1111);
        load_check("uart status cleared", 32'hAAAA_A404, 4'b1111);
        repeat (3) advance_cycle();

        if (tx_beats == 5 && disp_pulses == 1) begin
            $display("TEST OK");
            $finish;
        end else begin
            report_mismatch("uart beats and display pulses", {16'd5, 16'd1},
                            {16'(tx_beats), 16'(disp_pulses)});
        end
    end

endmodule

/* tb.f */
+incdir+hw
hw/mem_bus_pkg.sv
hw/mmio_pkg.sv
hw/store_aligner.sv
hw/mem_lane_bank.sv
hw/load_aligner.sv
hw/mmio_ctrl.sv
hw/memory_controller.sv
verif/tb_memory_controller.sv
